// File: source/x25519_pkg.sv
package x25519_pkg;

	localparam int limb_count = 32;	// radix 2^8 gives 32 limbs per element

	typedef logic [7:0] limb_t;	// one radix 2^8 digit
	typedef limb_t [limb_count-1:0] field_elem_t;	// limb 0 sits in the low byte
	typedef logic [31:0] column_t;	// one schoolbook column sum before carrying
	typedef logic [4:0] col_index_t;	// selects one of the 32 output columns

	localparam logic [7:0] reg_a_base = 8'h00;	// eight words of operand a
	localparam logic [7:0] reg_b_base = 8'h20;	// eight words of operand b
	localparam logic [7:0] reg_ctrl = 8'h40;	// bit 0 starts a multiply
	localparam logic [7:0] reg_status = 8'h44;	// bit 0 busy and bit 1 done
	localparam logic [7:0] reg_result_base = 8'h60;	// eight words of the product

	typedef enum logic [1:0] {
		ctrl_idle,	// waiting for a start write
		ctrl_issue,	// one column request per cycle
		ctrl_wait	// columns in flight until the squeeze finishes
	} ctrl_state_t;

	typedef enum logic [1:0] {
		sq_collect,	// column sums arrive from the pipeline
		sq_carry1,	// first carry and fold pass
		sq_carry2,	// second carry and fold pass
		sq_store	// product is valid for one cycle
	} squeeze_state_t;

endpackage

// File: source/column_issue_if.sv
`timescale 1ns/1ps
interface column_issue_if;
	import x25519_pkg::*;

	logic en;	// starts one column this cycle
	col_index_t i;	// column being requested
	field_elem_t a;	// operand a held steady for the whole run
	field_elem_t b;	// operand b held steady for the whole run

	modport issuer (
		output en,
		output i,
		output a,
		output b
	);

	modport worker (
		input en,
		input i,
		input a,
		input b
	);

endinterface

// File: source/x25519_mult_ctrl.sv
`timescale 1ns/1ps
module x25519_mult_ctrl #(
	parameter int addr_width = 8
) (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [addr_width-1:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic done_pulse,
	input x25519_pkg::field_elem_t product,
	column_issue_if.issuer issue
);
	import x25519_pkg::*;

	ctrl_state_t state;
	col_index_t i;	// next column to issue
	logic done;	// sticky until the next start
	logic busy;
	field_elem_t a_reg;	// operand a as written by the host
	field_elem_t b_reg;	// operand b as written by the host
	field_elem_t result;	// product latched when the squeeze finishes

	logic access;
	logic in_range;
	logic [2:0] word;	// word index inside an eight word block
	logic sel_a;
	logic sel_b;
	logic sel_ctrl;
	logic sel_status;
	logic sel_result;
	logic mapped;
	logic wr_err;
	logic wr_ok;
	logic start;

	assign busy = (state != ctrl_idle);	// covers issue and the wait for the squeeze
	assign pready = 1'b1;	// no wait states so every access completes at once

	assign access = psel && penable;	// APB access phase
	assign in_range = (paddr >> 7) == '0;	// everything lives in the low 128 bytes
	assign word = paddr[4:2];
	assign sel_a = in_range && (paddr[6:5] == reg_a_base[6:5]);
	assign sel_b = in_range && (paddr[6:5] == reg_b_base[6:5]);
	assign sel_ctrl = in_range && (paddr[6:2] == reg_ctrl[6:2]);
	assign sel_status = in_range && (paddr[6:2] == reg_status[6:2]);
	assign sel_result = in_range && (paddr[6:5] == reg_result_base[6:5]);
	assign mapped = sel_a || sel_b || sel_ctrl || sel_status || sel_result;	// 0x48 to 0x5c is a hole

	// status and result are read only and the operands are locked while a run is busy
	assign wr_err = pwrite && (sel_status || sel_result || (busy && (sel_a || sel_b || sel_ctrl)));
	assign pslverr = access && (!mapped || wr_err);
	assign wr_ok = access && pwrite && mapped && !wr_err;	// implies not busy for a, b and ctrl
	assign start = wr_ok && sel_ctrl && pwdata[0];	// a start while busy is dropped as an error

	always_comb begin
		prdata = '0;	// unmapped and ctrl reads return zero
		if (psel && !pwrite) begin
			if (sel_a) begin
				prdata = a_reg[{word, 2'b00} +: 4];	// four limbs per word
			end else if (sel_b) begin
				prdata = b_reg[{word, 2'b00} +: 4];
			end else if (sel_status) begin
				prdata = {30'd0, done, busy};
			end else if (sel_result) begin
				prdata = result[{word, 2'b00} +: 4];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_ok && sel_a) begin
			a_reg[{word, 2'b00} +: 4] <= pwdata;	// word 0 holds limbs 0 to 3
		end
		if (wr_ok && sel_b) begin
			b_reg[{word, 2'b00} +: 4] <= pwdata;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ctrl_idle;
			i <= '0;
			done <= 1'b0;
			result <= '0;
		end else begin
			case (state)
				ctrl_idle: begin
					if (start) begin
						state <= ctrl_issue;	// column 0 goes out next cycle
						done <= 1'b0;
					end
				end
				ctrl_issue: begin
					i <= i + 1'b1;	// wraps back to 0 after column 31
					if (i == col_index_t'(limb_count - 1)) begin
						state <= ctrl_wait;
					end
				end
				ctrl_wait: begin
					if (done_pulse) begin
						result <= product;	// readable from the next cycle
						done <= 1'b1;
						state <= ctrl_idle;
					end
				end
				default: begin
					state <= ctrl_idle;
				end
			endcase
		end
	end

	assign issue.en = (state == ctrl_issue);	// one column per cycle with no back-pressure
	assign issue.i = i;
	assign issue.a = a_reg;
	assign issue.b = b_reg;

	// the column index is back at zero whenever no issue sequence runs, so a run starts at column 0
	assert property (@(posedge clk) disable iff (reset)
		(state != ctrl_issue) |-> (i == '0));

	// the squeeze can only finish a run that this controller started
	assert property (@(posedge clk) disable iff (reset)
		done_pulse |-> (state != ctrl_idle));

endmodule

// File: source/x25519_column_mult.sv
`timescale 1ns/1ps
module x25519_column_mult (
	input logic clk,
	input logic reset,
	column_issue_if.worker issue,
	output logic out_valid,
	output x25519_pkg::column_t out
);
	import x25519_pkg::*;

	col_index_t b_index [limb_count];	// limb of b paired with limb j of a
	logic [15:0] prod [limb_count];	// raw 8 by 8 products
	logic [limb_count-1:0] do38;	// terms that wrapped past limb 31
	column_t term [limb_count];	// products after the optional times 38
	column_t sum4 [8];	// first adder level
	column_t sum2 [2];	// second adder level
	logic v1;
	logic v2;
	logic v3;
	logic v4;

	always_comb begin
		for (int j = 0; j < limb_count; j++) begin
			b_index[j] = issue.i - col_index_t'(j);	// 5 bit wrap gives i-j+32 when j > i
		end
	end

	always_ff @(posedge clk) begin
		if (issue.en) begin
			for (int j = 0; j < limb_count; j++) begin
				prod[j] <= issue.a[j] * issue.b[b_index[j]];
				do38[j] <= (j > issue.i);	// 2^256 folds to 38 mod p
			end
		end
	end

	always_ff @(posedge clk) begin
		if (v1) begin
			for (int j = 0; j < limb_count; j++) begin
				if (do38[j]) begin
					term[j] <= column_t'(prod[j]) * 32'd38;	// at most 22 bits
				end else begin
					term[j] <= column_t'(prod[j]);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (v2) begin
			for (int k = 0; k < 8; k++) begin
				sum4[k] <= term[4*k] + term[4*k+1] + term[4*k+2] + term[4*k+3];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (v3) begin
			for (int k = 0; k < 2; k++) begin
				sum2[k] <= sum4[4*k] + sum4[4*k+1] + sum4[4*k+2] + sum4[4*k+3];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (v4) begin
			out <= sum2[0] + sum2[1];	// a full column stays well under 2^27
		end
	end

	// Valid runs alongside the data so the latency is exactly five cycles.
	always_ff @(posedge clk) begin
		if (reset) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			v3 <= 1'b0;
			v4 <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			v1 <= issue.en;	// products registered
			v2 <= v1;	// scaled terms registered
			v3 <= v2;	// eight partial sums
			v4 <= v3;	// two partial sums
			out_valid <= v4;	// column sum ready
		end
	end

endmodule

// File: source/x25519_squeeze.sv
`timescale 1ns/1ps
module x25519_squeeze (
	input logic clk,
	input logic reset,
	input logic out_valid,
	input x25519_pkg::column_t out,
	output logic done_pulse,
	output x25519_pkg::field_elem_t product
);
	import x25519_pkg::*;

	squeeze_state_t state;
	col_index_t count;	// next accumulator slot to fill
	column_t acc [limb_count];	// column sums and later the carried limbs
	column_t pass [limb_count];	// acc after one carry and fold pass
	column_t u;	// running carry through the pass

	// One full pass is shared by both carry states.
	always_comb begin
		u = '0;
		for (int j = 0; j < limb_count - 1; j++) begin
			u = u + acc[j];
			pass[j] = {24'd0, u[7:0]};	// keep 8 bits in limbs 0 to 30
			u = u >> 8;
		end
		u = u + acc[limb_count-1];
		pass[limb_count-1] = {25'd0, u[6:0]};	// limb 31 keeps bits 248 to 254
		u = u >> 7;
		pass[0] = pass[0] + u * 32'd19;	// 2^255 is 19 mod p
	end

	always_ff @(posedge clk) begin
		if (state == sq_collect && out_valid) begin
			acc[count] <= out;	// columns come back in issue order
		end else if (state == sq_carry1 || state == sq_carry2) begin
			for (int j = 0; j < limb_count; j++) begin
				acc[j] <= pass[j];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= sq_collect;
			count <= '0;
		end else begin
			case (state)
				sq_collect: begin
					if (out_valid) begin
						count <= count + 1'b1;	// wraps to 0 ready for the next run
						if (count == col_index_t'(limb_count - 1)) begin
							state <= sq_carry1;
						end
					end
				end
				sq_carry1: begin
					state <= sq_carry2;
				end
				sq_carry2: begin
					state <= sq_store;
				end
				default: begin
					state <= sq_collect;	// sq_store lasts a single cycle
				end
			endcase
		end
	end

	assign done_pulse = (state == sq_store);

	always_comb begin
		for (int j = 0; j < limb_count; j++) begin
			product[j] = acc[j][7:0];	// low byte of each carried limb
		end
	end

	// the controller must not issue a new run before the last one is squeezed
	assert property (@(posedge clk) disable iff (reset)
		out_valid |-> (state == sq_collect));

endmodule

// File: source/x25519_mult_top.sv
`timescale 1ns/1ps
module x25519_mult_top #(
	parameter int addr_width = 8
) (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [addr_width-1:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr
);
	import x25519_pkg::*;

	logic col_valid;	// one column sum per cycle while a run drains
	column_t col_sum;
	logic done_pulse;	// squeezed product is valid this cycle
	field_elem_t product;

	column_issue_if issue_bus ();	// controller to column pipeline

	x25519_mult_ctrl #(
		.addr_width(addr_width)
	) u_ctrl (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.done_pulse(done_pulse),
		.product(product),
		.issue(issue_bus.issuer)
	);

	x25519_column_mult u_column (
		.clk(clk),
		.reset(reset),
		.issue(issue_bus.worker),
		.out_valid(col_valid),
		.out(col_sum)
	);

	x25519_squeeze u_squeeze (
		.clk(clk),
		.reset(reset),
		.out_valid(col_valid),
		.out(col_sum),
		.done_pulse(done_pulse),
		.product(product)
	);

endmodule

// File: verification/x25519_mult_tb.sv
`timescale 1ns/1ps
module x25519_mult_tb;
	import x25519_pkg::*;

	localparam int vec_count = 12;	// lines in the vector file
	localparam int max_wait = 20;	// cycles allowed for pready
	localparam int max_polls = 100;	// status reads allowed per multiply

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	logic [255:0] vectors [3*vec_count];	// a, b and expected product for each vector
	int error_count;	// wrong values
	int timeout_count;	// waits that ran out

	x25519_mult_top #(
		.addr_width(8)
	) u_dut (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	always #20 clk = ~clk;	// 40 ns period

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		int waited;
		waited = 0;
		@(posedge clk);
		psel <= 1'b1;	// setup phase
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;	// access phase starts here
		@(negedge clk);
		while (!pready && waited < max_wait) begin
			@(negedge clk);
			waited++;
		end
		if (!pready) begin
			$display("APB transfer to address %h never completed", addr);
			timeout_count++;
		end
		rdata = prdata;	// sampled mid cycle while the access phase is stable
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused;
		apb_access(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		apb_access(1'b0, addr, 32'd0, data, err);
	endtask

	task automatic load_operands(input int idx);
		logic err;
		for (int k = 0; k < 8; k++) begin
			apb_write(reg_a_base + 8'(4*k), vectors[3*idx][32*k +: 32], err);
			check_value("operand a write error", 32'd0, {31'd0, err});
			apb_write(reg_b_base + 8'(4*k), vectors[3*idx+1][32*k +: 32], err);
			check_value("operand b write error", 32'd0, {31'd0, err});
		end
	endtask

	task automatic start_run(input string name);
		logic err;
		logic [31:0] data;
		apb_write(reg_ctrl, 32'd1, err);
		check_value({name, " start error"}, 32'd0, {31'd0, err});
		apb_read(reg_status, data, err);
		check_value({name, " status after start"}, 32'h1, data);	// busy with done cleared
	endtask

	task automatic wait_done(input string name);
		logic err;
		logic [31:0] data;
		int polls;
		polls = 0;
		data = '0;
		while (!data[1] && polls < max_polls) begin
			apb_read(reg_status, data, err);
			polls++;
		end
		if (!data[1]) begin
			$display("%s never reported done", name);
			timeout_count++;
		end
		check_value({name, " status when done"}, 32'h2, data);
	endtask

	task automatic check_result(input int idx, input string name);
		logic err;
		logic [31:0] data;
		for (int k = 0; k < 8; k++) begin
			apb_read(reg_result_base + 8'(4*k), data, err);
			check_value($sformatf("%s result word %0d", name, k), vectors[3*idx+2][32*k +: 32], data);
		end
	endtask

	task automatic run_vector(input int idx);
		string name;
		name = $sformatf("vector %0d", idx);
		load_operands(idx);
		start_run(name);
		wait_done(name);
		check_result(idx, name);
	endtask

	// operand writes and a second start are refused while the unit is busy
	task automatic check_busy_errors(input int idx);
		string name;
		logic err;
		logic [31:0] data;
		name = $sformatf("locked vector %0d", idx);
		load_operands(idx);
		start_run(name);
		apb_write(reg_a_base, ~vectors[3*idx][31:0], err);
		check_value("write a while busy error", 32'd1, {31'd0, err});
		apb_write(reg_ctrl, 32'd1, err);
		check_value("second start error", 32'd1, {31'd0, err});
		wait_done(name);
		check_result(idx, name);
		apb_read(reg_a_base, data, err);
		check_value("operand a after refused write", vectors[3*idx][31:0], data);
	endtask

	initial begin
		logic [31:0] data;
		logic err;
		int idx;
		clk = 1'b0;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		error_count = 0;
		timeout_count = 0;
		void'($urandom(32'hc1e0));	// one seed for the whole run
		$readmemh("verification/x25519_mult_testdata.txt", vectors);
		if ($isunknown(vectors[3*vec_count-1])) begin
			$display("the vector file is missing or holds too few vectors");
			error_count++;
		end
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		apb_read(reg_status, data, err);	// nothing has run yet
		check_value("status after reset", 32'h0, data);
		check_value("status read error", 32'd0, {31'd0, err});
		for (int k = 0; k < 8; k++) begin
			apb_read(reg_result_base + 8'(4*k), data, err);
			check_value($sformatf("result word %0d after reset", k), 32'h0, data);
		end

		for (int k = 0; k < 8; k++) begin
			apb_write(reg_a_base + 8'(4*k), 32'h9e3779b9 * (k + 1), err);
			apb_write(reg_b_base + 8'(4*k), ~(32'h9e3779b9 * (k + 1)), err);
		end
		for (int k = 0; k < 8; k++) begin
			apb_read(reg_a_base + 8'(4*k), data, err);
			check_value($sformatf("operand a word %0d readback", k), 32'h9e3779b9 * (k + 1), data);
			apb_read(reg_b_base + 8'(4*k), data, err);
			check_value($sformatf("operand b word %0d readback", k), ~(32'h9e3779b9 * (k + 1)), data);
		end

		apb_read(8'h48, data, err);	// hole between status and result
		check_value("unmapped read error", 32'd1, {31'd0, err});
		apb_write(8'h5c, 32'h1234, err);
		check_value("unmapped write error", 32'd1, {31'd0, err});
		apb_read(8'h80, data, err);	// above the register block
		check_value("high address read error", 32'd1, {31'd0, err});
		apb_write(reg_status, 32'h3, err);
		check_value("status write error", 32'd1, {31'd0, err});
		apb_write(reg_result_base, 32'hffff, err);
		check_value("result write error", 32'd1, {31'd0, err});

		for (int n = 0; n < vec_count; n++) begin
			run_vector(n);	// file order, where most runs follow a different product
		end
		check_busy_errors(vec_count - 1);
		for (int n = 0; n < 10; n++) begin
			idx = int'($urandom % vec_count);	// back to back in random order
			run_vector(idx);
		end

		$display("%0d wrong values and %0d timeouts", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: x25519_mult.f
source/x25519_pkg.sv
source/column_issue_if.sv
source/x25519_mult_ctrl.sv
source/x25519_column_mult.sv
source/x25519_squeeze.sv
source/x25519_mult_top.sv
verification/x25519_mult_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the x25519 multiplier testbench with Verilator and runs it from the project root.
set -u
cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator was not found on the PATH"
	exit 1
fi

verilator --binary --timing --assert -Wno-fatal --top-module x25519_mult_tb -f x25519_mult.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vx25519_mult_tb)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "All tests passed"; then
	exit 0
fi
exit 1

// File: verification/x25519_mult_testdata.txt
// one vector per line: operand a, operand b, expected product
// each value is 64 hex digits, most significant first, limb 0 in the last two digits
0000000000000000000000000000000000000000000000000000000000000000 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 0000000000000000000000000000000000000000000000000000000000000000
0000000000000000000000000000000000000000000000000000000000000001 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef
0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef 0000000000000000000000000000000000000000000000000000000000000001 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef
7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffee
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 0000000000000000000000000000000000000000000000000000000000000001 0000000000000000000000000000000000000000000000000000000000000025
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 0000000000000000000000000000000000000000000000000000000000000559
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffe 0000000000000000000000000000000000000000000000000000000000000534
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 8000000000000000000000000000000000000000000000000000000000000000 00000000000000000000000000000000000000000000000000000000000002bf
0000000000000000000000000000000000000000000000000000000000000002 0000000000000000000000000000000000000000000000000000000000000003 0000000000000000000000000000000000000000000000000000000000000006
0000000000000000000000000000000100000000000000000000000000000000 0000000000000000000000000000000100000000000000000000000000000000 0000000000000000000000000000000000000000000000000000000000000026
7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 0000000000000000000000000000000000000000000000000000000000000002 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffeb
7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef 7edcba9876543210fedcba9876543210fedcba9876543210fedcba98765431fe
